//--- Bender.yml
package:
  name: slave_translator

sources:
  - source/avalon_bus_pkg.sv
  - source/slave_timing_pkg.sv
  - source/wait_state_sequencer.sv
  - source/read_latency_tracker.sv
  - source/transfer_marker.sv
  - source/address_translator.sv
  - source/slave_translator_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_slave_translator.sv

//--- compile.f
+incdir+sim
source/avalon_bus_pkg.sv
source/slave_timing_pkg.sv
source/wait_state_sequencer.sv
source/read_latency_tracker.sv
source/transfer_marker.sv
source/address_translator.sv
source/slave_translator_top.sv
sim/tb_slave_translator.sv

//--- sim/tb_check_tasks.svh
// compare tasks and pass/fail counters, included inside the testbench module
// expects avalon_bus_pkg to be imported by the including module
`ifndef TB_CHECK_TASKS_SVH
`define TB_CHECK_TASKS_SVH

int    pass_count = 0;
int    fail_count = 0;
string current_test = "setup";

task automatic record_result(input logic ok, input string what, input string expected,
                             input string actual);
   if (ok) begin
      pass_count++;
   end else begin
      fail_count++;
      $display("CHECK FAILED %s %s: expected %s, actual %s",
               current_test, what, expected, actual);
   end
endtask

task automatic check_bit(input string what, input logic expected, input logic actual);
   record_result(actual === expected, what, $sformatf("%b", expected), $sformatf("%b", actual));
endtask

task automatic check_data(input string what, input logic [DATA_W-1:0] expected,
                          input logic [DATA_W-1:0] actual);
   record_result(actual === expected, what, $sformatf("%h", expected), $sformatf("%h", actual));
endtask

task automatic check_enables(input string what, input logic [BYTEENABLE_W-1:0] expected,
                             input logic [BYTEENABLE_W-1:0] actual);
   record_result(actual === expected, what, $sformatf("%b", expected), $sformatf("%b", actual));
endtask

// only the word view matters on the slave side
task automatic check_address(input string what, input uav_address_u expected,
                             input uav_address_u actual);
   record_result(actual.parts.word_index === expected.parts.word_index, what,
                 $sformatf("word %h", expected.parts.word_index),
                 $sformatf("word %h", actual.parts.word_index));
endtask

task automatic check_count(input string what, input logic [AV_BURSTCOUNT_W-1:0] expected,
                           input logic [AV_BURSTCOUNT_W-1:0] actual);
   record_result(actual === expected, what, $sformatf("%0d", expected), $sformatf("%0d", actual));
endtask

task automatic check_number(input string what, input int expected, input int actual);
   record_result(actual == expected, what, $sformatf("%0d", expected), $sformatf("%0d", actual));
endtask

`endif

//--- sim/tb_slave_translator.sv
// testbench for slave_translator_top with a fixed-timing slave model behind it
// slave memory is 64 words, test addresses stay below word 64
`timescale 1ns/1ps
`default_nettype none

module tb_slave_translator
   import avalon_bus_pkg::*, slave_timing_pkg::*;
();

   localparam int TIMEOUT_CYCLES = 50;
   localparam int MEM_WORDS      = 64;
   localparam int SLAVE_READ_RUN = READ_DONE_COUNT - SETUP_CYCLES;  // av_read cycles before capture

   // request cycles seen on the master port, cycle 0 is the first one
   localparam int FIRST_STROBE_CYCLE = 1;   // av_read / av_write rise
   localparam int LAST_WRITE_CYCLE   = 2;
   localparam int ACCEPT_CYCLE       = 3;   // reads and writes alike

   logic                        clk;
   logic                        reset;
   uav_address_u                uav_address;
   logic [DATA_W-1:0]           uav_writedata;
   logic                        uav_write;
   logic                        uav_read;
   logic [UAV_BURSTCOUNT_W-1:0] uav_burstcount;
   logic [BYTEENABLE_W-1:0]     uav_byteenable;
   logic                        uav_waitrequest;
   logic                        uav_readdatavalid;
   logic [DATA_W-1:0]           uav_readdata;
   logic [AV_ADDRESS_W-1:0]     av_address;
   logic [AV_BURSTCOUNT_W-1:0]  av_burstcount;
   logic [DATA_W-1:0]           av_writedata;
   logic [BYTEENABLE_W-1:0]     av_byteenable;
   logic [BYTEENABLE_W-1:0]     av_writebyteenable;
   logic                        av_read;
   logic                        av_write;
   logic                        av_begintransfer;
   logic                        av_beginbursttransfer;
   logic                        av_chipselect;
   logic                        av_outputenable;
   logic [DATA_W-1:0]           av_readdata = '0;

   logic [DATA_W-1:0] slave_mem [MEM_WORDS];
   logic [DATA_W-1:0] shadow_mem [MEM_WORDS];
   logic [DATA_W-1:0] read_stage = '0;
   int                read_run = 0;
   logic [DATA_W-1:0] expected_data_q [$];
   int                accept_cycle_q [$];
   int                cycle_no = 0;
   int                valid_count = 0;
   int                begin_pulses;
   int                burst_pulses;
   int                test_fail_start;
   logic [31:0]       rng_state = 32'h5701796f;

   `include "tb_check_tasks.svh"

   slave_translator_top dut_i (.*);

   always #5 clk = ~clk;

   always @(posedge clk) cycle_no <= cycle_no + 1;

   // --------------------------------------------------
   // reference and helpers
   // --------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic logic [DATA_W-1:0] fill_word(input int index);
      return 32'h5a5a0000 ^ (index * 32'h01030507);
   endfunction

   // expected slave word after a byte-enabled write
   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
      input logic [DATA_W-1:0] new_word, input logic [BYTEENABLE_W-1:0] enables);
      logic [DATA_W-1:0] merged;
      merged = old_word;
      for (int b = 0; b < BYTEENABLE_W; b++) begin
         if (enables[b])
            merged[8*b +: 8] = new_word[8*b +: 8];
      end
      return merged;
   endfunction

   function automatic uav_address_u word_address(input int word);
      uav_address_u a;
      a.byte_addr        = '0;
      a.parts.word_index = word[AV_ADDRESS_W-1:0];
      return a;
   endfunction

   task automatic abort_run(input string reason);
      $display("%s: %s", current_test, reason);
      $display("STATUS: FAIL");
      $finish;
   endtask

   // --------------------------------------------------
   // slave model, fixed timing
   // --------------------------------------------------
   always @(posedge clk) begin
      if (reset) begin
         read_run <= 0;
         for (int i = 0; i < MEM_WORDS; i++)
            slave_mem[i] <= fill_word(i);
      end else begin
         for (int b = 0; b < BYTEENABLE_W; b++) begin
            if (av_write && av_writebyteenable[b])
               slave_mem[av_address[5:0]][8*b +: 8] <= av_writedata[8*b +: 8];
         end
         read_run <= av_read ? read_run + 1 : 0;
         if (av_read && read_run == SLAVE_READ_RUN)
            read_stage <= slave_mem[av_address[5:0]];
         av_readdata <= read_stage;   // second stage of the read pipe
      end
   end

   // read result checker
   always @(posedge clk) begin
      logic [DATA_W-1:0] expected;
      int                accepted_at;
      if (!reset && uav_readdatavalid) begin
         valid_count++;
         if (expected_data_q.size() == 0) begin
            fail_count++;
            $display("%s: readdatavalid with no read outstanding", current_test);
         end else begin
            expected    = expected_data_q.pop_front();
            accepted_at = accept_cycle_q.pop_front();
            check_data("uav_readdata", expected, uav_readdata);
            check_number("readdatavalid cycle", accepted_at + READ_LATENCY, cycle_no);
         end
      end
   end

   // --------------------------------------------------
   // stimulus tasks, each starts and ends on a rising edge
   // --------------------------------------------------
   task automatic run_beat(input logic is_write, input uav_address_u addr,
                           input logic [DATA_W-1:0] data, input logic [BYTEENABLE_W-1:0] be,
                           input logic [UAV_BURSTCOUNT_W-1:0] burst,
                           input uav_address_u hold_addr);
      uav_address_u               seen_addr;
      logic [AV_BURSTCOUNT_W-1:0] words;
      logic                       accepted;
      int                         k;
      words    = AV_BURSTCOUNT_W'(burst / BYTES_PER_WORD);
      accepted = 1'b0;
      uav_address    <= addr;
      uav_writedata  <= data;
      uav_byteenable <= be;
      uav_burstcount <= burst;
      uav_write      <= is_write;
      uav_read       <= !is_write;
      for (k = 0; k < TIMEOUT_CYCLES && !accepted; k++) begin
         @(posedge clk);
         seen_addr                  = '0;
         seen_addr.parts.word_index = av_address;
         check_address("av_address", hold_addr, seen_addr);
         check_count("av_burstcount", words, av_burstcount);
         check_bit("av_write",
                   is_write && k >= FIRST_STROBE_CYCLE && k <= LAST_WRITE_CYCLE, av_write);
         check_bit("av_read", !is_write && k >= FIRST_STROBE_CYCLE, av_read);
         check_enables("av_byteenable", be, av_byteenable);
         check_enables("av_writebyteenable", is_write ? be : '0, av_writebyteenable);
         if (!is_write) begin
            check_bit("av_chipselect", 1'b1, av_chipselect);
            check_bit("av_outputenable", 1'b1, av_outputenable);
         end
         begin_pulses += av_begintransfer;
         burst_pulses += av_beginbursttransfer;
         if (!uav_waitrequest) begin
            accepted = 1'b1;
            check_number("accept cycle", ACCEPT_CYCLE, k);
            if (is_write) begin
               shadow_mem[hold_addr.parts.word_index[5:0]] =
                  merge_bytes(shadow_mem[hold_addr.parts.word_index[5:0]], data, be);
            end else begin
               expected_data_q.push_back(shadow_mem[hold_addr.parts.word_index[5:0]]);
               accept_cycle_q.push_back(cycle_no);
            end
         end
      end
      if (!accepted)
         abort_run("request was not accepted within 50 cycles");
   endtask

   task automatic end_request();
      uav_read  <= 1'b0;
      uav_write <= 1'b0;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   task automatic wait_for_valid(input logic watch_selects);
      logic seen;
      int   k;
      seen = 1'b0;
      for (k = 0; k < TIMEOUT_CYCLES && !seen; k++) begin
         @(posedge clk);
         if (watch_selects) begin   // read still in flight
            check_bit("av_chipselect", 1'b1, av_chipselect);
            check_bit("av_outputenable", 1'b1, av_outputenable);
         end
         seen = uav_readdatavalid;
      end
      if (!seen)
         abort_run("readdatavalid did not arrive within 50 cycles");
   endtask

   task automatic start_test(input string name);
      current_test    = name;
      test_fail_start = fail_count;
   endtask

   task automatic end_test();
      if (fail_count == test_fail_start)
         $display("test %s: passed", current_test);
      else
         $display("test %s: %0d errors", current_test, fail_count - test_fail_start);
   endtask

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------
   initial begin
      int                      word_list [8];
      int                      base;
      int                      valid_start;
      logic [BYTEENABLE_W-1:0] be;
      uav_address_u            beat_addr;
      clk            = 1'b0;
      reset          = 1'b1;
      uav_address    = '0;
      uav_writedata  = '0;
      uav_write      = 1'b0;
      uav_read       = 1'b0;
      uav_burstcount = '0;
      uav_byteenable = '0;
      for (int i = 0; i < MEM_WORDS; i++)
         shadow_mem[i] = fill_word(i);

      start_test("reset");
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);   // first cycle out of reset
      check_bit("uav_waitrequest", 1'b1, uav_waitrequest);
      check_bit("av_read", 1'b0, av_read);
      check_bit("av_write", 1'b0, av_write);
      check_bit("av_chipselect", 1'b0, av_chipselect);
      check_bit("uav_readdatavalid", 1'b0, uav_readdatavalid);
      idle_cycles(2);
      end_test();

      start_test("single timing");
      run_beat(1'b1, word_address(5), 32'hc0ffee11, 4'hf, 6'd4, word_address(5));
      end_request();
      idle_cycles(2);
      run_beat(1'b0, word_address(5), '0, 4'hf, 6'd4, word_address(5));
      end_request();
      wait_for_valid(1'b0);
      idle_cycles(2);
      end_test();

      start_test("read data");
      valid_start = valid_count;
      for (int i = 0; i < 8; i++) begin
         rng_state    = xorshift32(rng_state);
         word_list[i] = int'(rng_state[4:0]);
         be           = rng_state[11:8];
         rng_state    = xorshift32(rng_state);
         run_beat(1'b1, word_address(word_list[i]), rng_state, be, 6'd4,
                  word_address(word_list[i]));
      end
      end_request();
      idle_cycles(2);
      for (int i = 0; i < 8; i++)   // back to back, request held across beats
         run_beat(1'b0, word_address(word_list[i]), '0, 4'hf, 6'd4, word_address(word_list[i]));
      end_request();
      wait_for_valid(1'b0);
      idle_cycles(1);
      check_number("readdatavalid pulses", 8, valid_count - valid_start);
      idle_cycles(2);
      end_test();

      start_test("write burst");
      rng_state    = xorshift32(rng_state);
      base         = 40 + int'(rng_state[2:0]);
      begin_pulses = 0;
      burst_pulses = 0;
      for (int i = 0; i < 4; i++) begin
         beat_addr.byte_addr = UAV_ADDRESS_W'((base + i) * BYTES_PER_WORD);
         rng_state           = xorshift32(rng_state);
         run_beat(1'b1, beat_addr, rng_state, 4'hf, 6'd16, word_address(base));
      end
      end_request();
      check_number("begintransfer pulses", 4, begin_pulses);
      check_number("beginbursttransfer pulses", 1, burst_pulses);
      idle_cycles(3);
      end_test();

      start_test("read selects");
      check_bit("idle av_chipselect", 1'b0, av_chipselect);
      check_bit("idle av_outputenable", 1'b0, av_outputenable);
      run_beat(1'b0, word_address(base), '0, 4'hf, 6'd4, word_address(base));
      end_request();
      wait_for_valid(1'b1);
      idle_cycles(1);
      check_bit("idle av_chipselect", 1'b0, av_chipselect);
      check_bit("idle av_outputenable", 1'b0, av_outputenable);
      end_test();

      $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
      if (fail_count == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- source/address_translator.sv
// byte address and byte burstcount to slave words
// assumes word aligned addresses and burstcounts in whole words
`timescale 1ns/1ps
`default_nettype none

module address_translator
   import avalon_bus_pkg::*;
(
   input  wire                        clk,
   input  wire                        reset,
   input  wire uav_address_u          uav_address,
   input  wire [UAV_BURSTCOUNT_W-1:0] uav_burstcount,
   input  wire                        av_beginbursttransfer,
   output logic [AV_ADDRESS_W-1:0]    av_address,
   output logic [AV_BURSTCOUNT_W-1:0] av_burstcount
);

   logic [AV_ADDRESS_W-1:0]    address_live;
   logic [AV_ADDRESS_W-1:0]    address_hold;
   logic [AV_BURSTCOUNT_W-1:0] burst_words;
   logic [AV_BURSTCOUNT_W-1:0] burst_hold;

   // --------------------------------------------------
   // byte to word conversion
   // --------------------------------------------------
   assign address_live = uav_address.parts.word_index;   // byte lane bits dropped
   assign burst_words  = uav_burstcount[BYTE_OFFSET_W +: AV_BURSTCOUNT_W];

   // --------------------------------------------------
   // burst hold
   // --------------------------------------------------
   // captured in the burst's first cycle, kept until the next burst
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         address_hold <= '0;
         burst_hold   <= '0;
      end else if (av_beginbursttransfer) begin
         address_hold <= address_live;
         burst_hold   <= burst_words;
      end
   end

   // live in the first cycle, held values after it
   always_comb begin
      if (av_beginbursttransfer) begin
         av_address    = address_live;
         av_burstcount = burst_words;
      end else begin
         av_address    = address_hold;
         av_burstcount = burst_hold;
      end
   end

endmodule

`default_nettype wire

//--- source/avalon_bus_pkg.sv
// bus shapes of both ports, byte addressed master and word addressed slave
// data width is the same on both sides, no width conversion
`default_nettype none

package avalon_bus_pkg;

   // --------------------------------------------------
   // widths
   // --------------------------------------------------
   localparam int UAV_ADDRESS_W    = 16;  // master byte address
   localparam int AV_ADDRESS_W     = 14;  // slave word address
   localparam int DATA_W           = 32;
   localparam int BYTES_PER_WORD   = 4;
   localparam int BYTE_OFFSET_W    = 2;
   localparam int BYTEENABLE_W     = 4;
   localparam int UAV_BURSTCOUNT_W = 6;   // counted in bytes
   localparam int AV_BURSTCOUNT_W  = 4;   // counted in words

   // master address, flat or split into word and byte lane
   typedef union packed {
      logic [UAV_ADDRESS_W-1:0] byte_addr;
      struct packed {
         logic [UAV_ADDRESS_W-BYTE_OFFSET_W-1:0] word_index;
         logic [BYTE_OFFSET_W-1:0]               byte_offset;
      } parts;
   } uav_address_u;

endpackage

`default_nettype wire

//--- source/read_latency_tracker.sv
// fixed pipe of READ_LATENCY stages, one bit per accepted read
// only single-word reads, each accept yields exactly one readdatavalid
`timescale 1ns/1ps
`default_nettype none

module read_latency_tracker
   import slave_timing_pkg::*;
(
   input  wire  clk,
   input  wire  reset,
   input  wire  uav_read,
   input  wire  uav_write,
   input  wire  uav_waitrequest,
   input  wire  reset_override,
   output logic uav_readdatavalid,
   output logic av_chipselect,
   output logic av_outputenable
);

   logic [READ_LATENCY-1:0] latency_pipe;  // bit 0 is the youngest read
   logic                    read_accept;
   logic                    read_pending;  // read in flight, not yet at the last stage
   logic                    read_extend;

   assign read_accept = uav_read && !uav_waitrequest && !reset_override;

   // --------------------------------------------------
   // latency pipe
   // --------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         latency_pipe <= '0;
      end else begin
         latency_pipe <= {latency_pipe[READ_LATENCY-2:0], read_accept};
      end
   end

   assign uav_readdatavalid = latency_pipe[READ_LATENCY-1];
   assign read_pending      = |latency_pipe[READ_LATENCY-2:0];

   // --------------------------------------------------
   // chipselect / outputenable stretch
   // --------------------------------------------------
   // registered, so it covers up to and including the valid cycle
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         read_extend <= 1'b0;
      end else begin
         read_extend <= uav_read || read_pending;
      end
   end

   assign av_chipselect   = uav_read || uav_write || read_extend;
   assign av_outputenable = uav_read || read_extend;   // never for writes alone

endmodule

`default_nettype wire

//--- source/slave_timing_pkg.sv
// fixed timing of the attached slave, all counts in clock cycles
// READ_LATENCY must be 2 or more, the tracker has no zero/one latency path
`default_nettype none

package slave_timing_pkg;

   // --------------------------------------------------
   // slave wait states
   // --------------------------------------------------
   localparam int SETUP_CYCLES      = 1;
   localparam int READ_WAIT_CYCLES  = 2;
   localparam int WRITE_WAIT_CYCLES = 1;
   localparam int HOLD_CYCLES       = 1;

   // counter values at which each phase ends
   localparam int READ_DONE_COUNT  = SETUP_CYCLES + READ_WAIT_CYCLES;
   localparam int WRITE_END_COUNT  = SETUP_CYCLES + WRITE_WAIT_CYCLES;  // last av_write cycle
   localparam int WRITE_DONE_COUNT = WRITE_END_COUNT + HOLD_CYCLES;

   // readdata arrives this many cycles after the accept
   localparam int READ_LATENCY = 2;

   // wide enough for the longer of the two done counts
   localparam int WAIT_COUNT_W =
      $clog2(((READ_DONE_COUNT > WRITE_DONE_COUNT) ? READ_DONE_COUNT : WRITE_DONE_COUNT) + 1);

endpackage

`default_nettype wire

//--- source/slave_translator_top.sv
// universal Avalon-MM slave port to a fixed-timing Avalon-MM slave
// reads are single word only, timing comes from slave_timing_pkg
`timescale 1ns/1ps
`default_nettype none

module slave_translator_top
   import avalon_bus_pkg::*;
(
   input  wire                        clk,
   input  wire                        reset,

   // --------------------------------------------------
   // master side
   // --------------------------------------------------
   input  wire uav_address_u          uav_address,
   input  wire [DATA_W-1:0]           uav_writedata,
   input  wire                        uav_write,
   input  wire                        uav_read,
   input  wire [UAV_BURSTCOUNT_W-1:0] uav_burstcount,
   input  wire [BYTEENABLE_W-1:0]     uav_byteenable,
   output logic                       uav_waitrequest,
   output logic                       uav_readdatavalid,
   output logic [DATA_W-1:0]          uav_readdata,

   // --------------------------------------------------
   // slave side
   // --------------------------------------------------
   output logic [AV_ADDRESS_W-1:0]    av_address,
   output logic [AV_BURSTCOUNT_W-1:0] av_burstcount,
   output logic [DATA_W-1:0]          av_writedata,
   output logic [BYTEENABLE_W-1:0]    av_byteenable,
   output logic [BYTEENABLE_W-1:0]    av_writebyteenable,
   output logic                       av_read,
   output logic                       av_write,
   output logic                       av_begintransfer,
   output logic                       av_beginbursttransfer,
   output logic                       av_chipselect,
   output logic                       av_outputenable,
   input  wire [DATA_W-1:0]           av_readdata
);

   logic reset_override;   // high in the first cycle after reset

   // data paths need no conversion, same width both sides
   assign av_writedata  = uav_writedata;
   assign av_byteenable = uav_byteenable;
   assign uav_readdata  = av_readdata;   // valid with uav_readdatavalid

   wait_state_sequencer wait_state_sequencer_i (
      .clk                (clk),
      .reset              (reset),
      .uav_read           (uav_read),
      .uav_write          (uav_write),
      .uav_byteenable     (uav_byteenable),
      .av_read            (av_read),
      .av_write           (av_write),
      .av_writebyteenable (av_writebyteenable),
      .uav_waitrequest    (uav_waitrequest),
      .reset_override     (reset_override)
   );

   read_latency_tracker read_latency_tracker_i (
      .clk               (clk),
      .reset             (reset),
      .uav_read          (uav_read),
      .uav_write         (uav_write),
      .uav_waitrequest   (uav_waitrequest),
      .reset_override    (reset_override),
      .uav_readdatavalid (uav_readdatavalid),
      .av_chipselect     (av_chipselect),
      .av_outputenable   (av_outputenable)
   );

   transfer_marker transfer_marker_i (
      .clk                   (clk),
      .reset                 (reset),
      .uav_read              (uav_read),
      .uav_write             (uav_write),
      .uav_burstcount        (uav_burstcount),
      .uav_waitrequest       (uav_waitrequest),
      .reset_override        (reset_override),
      .av_begintransfer      (av_begintransfer),
      .av_beginbursttransfer (av_beginbursttransfer)
   );

   // burst start marker decides when address and burstcount are captured
   address_translator address_translator_i (
      .clk                   (clk),
      .reset                 (reset),
      .uav_address           (uav_address),
      .uav_burstcount        (uav_burstcount),
      .av_beginbursttransfer (av_beginbursttransfer),
      .av_address            (av_address),
      .av_burstcount         (av_burstcount)
   );

endmodule

`default_nettype wire

//--- source/transfer_marker.sv
// beat and burst start markers for the slave
// burst length is taken from the first beat, later beats may repeat or count down
`timescale 1ns/1ps
`default_nettype none

module transfer_marker
   import avalon_bus_pkg::*;
(
   input  wire                        clk,
   input  wire                        reset,
   input  wire                        uav_read,
   input  wire                        uav_write,
   input  wire [UAV_BURSTCOUNT_W-1:0] uav_burstcount,
   input  wire                        uav_waitrequest,
   input  wire                        reset_override,
   output logic                       av_begintransfer,
   output logic                       av_beginbursttransfer
);

   logic                        end_begintransfer;  // rest of the current beat
   logic                        in_burst;           // write burst past its first beat
   logic [UAV_BURSTCOUNT_W-1:0] bytes_left;
   logic [UAV_BURSTCOUNT_W-1:0] beat_bytes;
   logic                        write_accept;

   assign av_begintransfer = (uav_read || uav_write) && !end_begintransfer;
   assign av_beginbursttransfer = uav_read ? av_begintransfer
                                           : (av_begintransfer && !in_burst);

   // --------------------------------------------------
   // beat tracking
   // --------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         end_begintransfer <= 1'b0;
      end else if (av_begintransfer && uav_waitrequest && !reset_override) begin
         end_begintransfer <= 1'b1;
      end else if (!uav_waitrequest) begin
         end_begintransfer <= 1'b0;   // next cycle starts a new beat
      end
   end

   // bytes still owed by the burst, this beat included
   assign beat_bytes   = in_burst ? bytes_left : uav_burstcount;
   assign write_accept = uav_write && !uav_waitrequest && !reset_override;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         in_burst <= 1'b0;
      end else if (write_accept) begin
         in_burst <= (beat_bytes != UAV_BURSTCOUNT_W'(BYTES_PER_WORD));
      end
   end

   always_ff @(posedge clk) begin
      if (write_accept)
         bytes_left <= beat_bytes - UAV_BURSTCOUNT_W'(BYTES_PER_WORD);
   end

endmodule

`default_nettype wire

//--- source/wait_state_sequencer.sv
// waitrequest comes only from the cycle counts, the slave has none of its own
// write wins when read and write are both high
`timescale 1ns/1ps
`default_nettype none

module wait_state_sequencer
   import avalon_bus_pkg::*, slave_timing_pkg::*;
(
   input  wire                    clk,
   input  wire                    reset,
   input  wire                    uav_read,
   input  wire                    uav_write,
   input  wire [BYTEENABLE_W-1:0] uav_byteenable,
   output logic                   av_read,
   output logic                   av_write,
   output logic [BYTEENABLE_W-1:0] av_writebyteenable,
   output logic                   uav_waitrequest,
   output logic                   reset_override
);

   logic [WAIT_COUNT_W-1:0] wait_count;
   logic                    read_wait;
   logic                    write_wait;

   // --------------------------------------------------
   // wait counter
   // --------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wait_count     <= '0;
         reset_override <= 1'b1;   // first cycle out of reset is never accepted
      end else begin
         reset_override <= 1'b0;
         if (!uav_waitrequest || reset_override)
            wait_count <= '0;      // beat accepted, restart for the next one
         else if (uav_read || uav_write)
            wait_count <= wait_count + 1'b1;
         else
            wait_count <= '0;      // idle
      end
   end

   // --------------------------------------------------
   // strobes and generated waitrequest
   // --------------------------------------------------
   always_comb begin
      av_read  = uav_read && (wait_count >= WAIT_COUNT_W'(SETUP_CYCLES));
      // write strobe closes before the data hold cycles
      av_write = uav_write
                 && (wait_count >= WAIT_COUNT_W'(SETUP_CYCLES))
                 && (wait_count <= WAIT_COUNT_W'(WRITE_END_COUNT));
      read_wait  = (wait_count != WAIT_COUNT_W'(READ_DONE_COUNT));
      write_wait = (wait_count != WAIT_COUNT_W'(WRITE_DONE_COUNT));
      uav_waitrequest = (uav_write ? write_wait : read_wait) || reset_override;
   end

   assign av_writebyteenable = {BYTEENABLE_W{uav_write}} & uav_byteenable;

endmodule

`default_nettype wire
